//--- src/uart_rx_settings.svh
/* Build-time sizes for the UART receive hub
   Include before any use of the RX_ macros */
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// Serial receive lines, one receiver each
`define RX_NUM_CHANNELS 4

// Result FIFO entries; STATUS count field is 4 bits wide
`define RX_FIFO_DEPTH 8

// Byte address bits of the register window
`define RX_AXI_ADDR_WIDTH 6

// Clocks per oversample tick after reset
`define RX_DEFAULT_DIVISOR 4

`endif

//--- src/uart_rx_pkg.sv
/* Types shared by the UART receive hub blocks
   Compile before any module of the hub */
package uart_rx_pkg;

  // Channel number carried with every frame
  typedef logic [1:0] chan_idx_t;

  // Per-channel setup, matches the CHAN_CFG register bits 3:0
  typedef struct packed {
    logic       enable;       // Receiver on
    logic [1:0] parity_mode;  // 0/1 none, 2 even, 3 odd
    logic       two_stop;     // Second stop bit expected
  } rx_config_t;

  // One received character as stored in the result FIFO
  typedef struct packed {
    chan_idx_t  channel;       // Source line
    logic       parity_error;  // Parity bit mismatch
    logic       frame_error;   // A stop bit voted low
    logic [7:0] data;          // Character, bit 0 first on the line
  } rx_frame_t;

endpackage

//--- src/baud_tick_gen.sv
/* Shared 16x oversample strobe for all receivers
   One clock pulse every divisor clocks, divisor 0 acts as 1 */
`timescale 1ns/1ps

module baud_tick_gen (
  input  logic        clock,
  input  logic        reset,
  input  logic [15:0] divisor,      // Clocks per tick, from DIVISOR register
  output logic        sample_tick   // Single-cycle pulse
);

  logic [15:0] tick_count;
  logic [15:0] reload_value;

  // Count from divisor-1 down to 0 gives a period of divisor clocks
  assign reload_value = (divisor == 16'd0) ? 16'd0 : divisor - 16'd1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end else if (tick_count == 16'd0) begin
      tick_count  <= reload_value;  // New divisor only picked up here
      sample_tick <= 1'b1;
    end else begin
      tick_count  <= tick_count - 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- src/uart_rx_channel.sv
/* Single UART receiver with 2-of-3 majority vote on samples 7, 8, 9 of each bit
   Checks optional parity and one or two stop bits, holds the frame until taken */
`timescale 1ns/1ps

module uart_rx_channel (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   sample_tick,     // 16 ticks per bit
  input  uart_rx_pkg::rx_config_t channel_config,
  input  uart_rx_pkg::chan_idx_t channel_id,      // Fixed per instance
  input  logic                   rxd,             // Serial line, idle high
  output logic                   frame_valid,
  input  logic                   frame_ready,
  output uart_rx_pkg::rx_frame_t frame
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop1,
    st_stop2
  } rx_state_t;

  rx_state_t  state;
  logic [3:0] sample_cnt;   // Tick position inside the current bit
  logic [2:0] bit_cnt;      // Data bit index
  logic [2:0] votes;        // Line samples 7, 8 and 9
  logic [7:0] shift;        // Data shift register, LSB arrives first
  logic       parity_err;
  logic       frame_err;    // Result of stop1
  logic       voted_bit;
  logic       bit_end;
  logic       frame_done;

  // Two of three samples decide the bit
  assign voted_bit = (votes[0] & votes[1]) | (votes[0] & votes[2]) | (votes[1] & votes[2]);
  assign bit_end   = sample_tick && (sample_cnt == 4'd15);  // Last tick of a bit

  // Frame ends on the last stop bit
  assign frame_done = bit_end && channel_config.enable &&
                      ((state == st_stop1 && !channel_config.two_stop) ||
                       state == st_stop2);

  // Oversample position, held at 0 while idle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) sample_cnt <= '0;
    else if (state == st_idle) sample_cnt <= '0;
    else if (sample_tick) sample_cnt <= sample_cnt + 4'd1;
  end

  // Capture the three mid-bit samples
  always_ff @(posedge clock) begin
    if (sample_tick) begin
      case (sample_cnt)
        4'd7:    votes[0] <= rxd;
        4'd8:    votes[1] <= rxd;
        4'd9:    votes[2] <= rxd;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
    end else if (!channel_config.enable) begin
      state <= st_idle;  // Disabled receiver parks here
    end else begin
      case (state)
        st_idle: if (!rxd) state <= st_start;  // Falling edge, possible start
        st_start: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= voted_bit ? st_idle : st_data;  // High vote is a false start
          end
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
              state <= channel_config.parity_mode[1] ? st_parity : st_stop1;
          end
        end
        st_parity: if (bit_end) state <= st_stop1;
        st_stop1: if (bit_end) state <= channel_config.two_stop ? st_stop2 : st_idle;
        st_stop2: if (bit_end) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Data and check results, sampled at the end of each bit
  always_ff @(posedge clock) begin
    if (bit_end) begin
      case (state)
        st_start: begin
          parity_err <= 1'b0;  // Fresh frame
          frame_err  <= 1'b0;
        end
        st_data:   shift <= {voted_bit, shift[7:1]};
        // Zero for matching even or odd parity
        st_parity: parity_err <= ^shift ^ voted_bit ^ channel_config.parity_mode[0];
        st_stop1:  frame_err <= ~voted_bit;
        default:   ;
      endcase
    end
  end

  // Stop2 only adds its own check when stop1 passed
  always_ff @(posedge clock) begin
    if (frame_done) begin
      frame <= '{channel:      channel_id,
                 parity_error: parity_err,
                 frame_error:  (state == st_stop2 && frame_err) || !voted_bit,
                 data:         shift};
    end
  end

  // Pending until the collector takes it; a new frame wins over a take
  always_ff @(posedge clock or posedge reset) begin
    if (reset) frame_valid <= 1'b0;
    else if (frame_done) frame_valid <= 1'b1;
    else if (frame_ready) frame_valid <= 1'b0;
  end

endmodule

//--- src/rx_frame_collector.sv
/* Round-robin drain of pending channel frames into the result FIFO
   Frames arriving on a full FIFO are dropped and flag a sticky overflow */
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module rx_frame_collector (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [`RX_NUM_CHANNELS-1:0]                   frame_valid,
  input  uart_rx_pkg::rx_frame_t [`RX_NUM_CHANNELS-1:0] frames,
  output logic [`RX_NUM_CHANNELS-1:0]                   frame_ready,
  input  logic                                          pop,        // Host read of RX_DATA
  output uart_rx_pkg::rx_frame_t                        head,       // Oldest entry
  output logic [3:0]                                    count,
  output logic                                          overflow,
  input  logic                                          clear_overflow
);
  import uart_rx_pkg::*;

  localparam int num_ch    = `RX_NUM_CHANNELS;
  localparam int ptr_width = $clog2(`RX_FIFO_DEPTH);

  chan_idx_t            last_grant;   // Search starts after this one
  chan_idx_t            grant_idx;
  logic                 grant_hit;
  logic                 stage_valid;  // Granted frame on its way to the FIFO
  rx_frame_t            stage_frame;
  rx_frame_t            mem [`RX_FIFO_DEPTH];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic                 full;
  logic                 do_write;
  logic                 do_read;

  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    ptr_next = (ptr == ptr_width'(`RX_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // First pending channel after the last grant
  always_comb begin
    int idx;
    grant_hit = 1'b0;
    grant_idx = last_grant;
    for (int k = 1; k <= num_ch; k++) begin
      idx = (int'(last_grant) + k) % num_ch;
      if (!grant_hit && frame_valid[idx]) begin
        grant_hit = 1'b1;
        grant_idx = chan_idx_t'(idx);
      end
    end
  end

  always_comb begin
    frame_ready = '0;
    if (grant_hit) frame_ready[grant_idx] = 1'b1;  // One-hot take
  end

  assign full     = (count == 4'(`RX_FIFO_DEPTH));
  assign do_write = stage_valid && !full;
  assign do_read  = pop && (count != 4'd0);
  assign head     = mem[rd_ptr];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      last_grant  <= chan_idx_t'(num_ch - 1);  // Channel 0 first after reset
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= grant_hit;
      if (grant_hit) last_grant <= grant_idx;
    end
  end

  always_ff @(posedge clock) begin
    if (grant_hit) stage_frame <= frames[grant_idx];
    if (do_write) mem[wr_ptr] <= stage_frame;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) wr_ptr <= ptr_next(wr_ptr);
      if (do_read) rd_ptr <= ptr_next(rd_ptr);
      case ({do_write, do_read})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: ;  // Both or neither leaves the level alone
      endcase
    end
  end

  // Set beats clear so no loss goes unreported
  always_ff @(posedge clock or posedge reset) begin
    if (reset) overflow <= 1'b0;
    else if (stage_valid && full) overflow <= 1'b1;
    else if (clear_overflow) overflow <= 1'b0;
  end

endmodule

//--- src/axil_rx_regs.sv
/* AXI4-Lite register block for the receive hub
   Divisor and channel setup registers, STATUS, and the RX_DATA pop port */
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module axil_rx_regs (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [`RX_AXI_ADDR_WIDTH-1:0]                 awaddr,
  input  logic                                          awvalid,
  output logic                                          awready,
  input  logic [31:0]                                   wdata,
  input  logic                                          wvalid,
  output logic                                          wready,
  output logic [1:0]                                    bresp,
  output logic                                          bvalid,
  input  logic                                          bready,
  input  logic [`RX_AXI_ADDR_WIDTH-1:0]                 araddr,
  input  logic                                          arvalid,
  output logic                                          arready,
  output logic [31:0]                                   rdata,
  output logic [1:0]                                    rresp,
  output logic                                          rvalid,
  input  logic                                          rready,
  output logic [15:0]                                   divisor,
  output uart_rx_pkg::rx_config_t [`RX_NUM_CHANNELS-1:0] channel_config,
  output logic                                          pop,
  output logic                                          clear_overflow,
  input  uart_rx_pkg::rx_frame_t                        head,
  input  logic [3:0]                                    count,
  input  logic                                          overflow
);

  localparam int num_ch      = `RX_NUM_CHANNELS;
  localparam int status_word = `RX_NUM_CHANNELS + 1;  // 0x14
  localparam int data_word   = `RX_NUM_CHANNELS + 2;  // 0x18

  logic                          wr_fire;
  logic                          rd_fire;
  logic [`RX_AXI_ADDR_WIDTH-3:0] wr_word;  // Word index of the byte address
  logic [`RX_AXI_ADDR_WIDTH-3:0] rd_word;
  logic [31:0]                   rd_value;
  logic                          rd_error;

  // AW and W taken together, only with no B outstanding
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bresp   = 2'b00;  // Writes always OKAY
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign wr_word = awaddr[`RX_AXI_ADDR_WIDTH-1:2];
  assign rd_word = araddr[`RX_AXI_ADDR_WIDTH-1:2];

  assign pop            = rd_fire && (int'(rd_word) == data_word) && (count != 4'd0);
  assign clear_overflow = rd_fire && (int'(rd_word) == status_word);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      divisor        <= 16'(`RX_DEFAULT_DIVISOR);
      channel_config <= '0;  // All channels off
      bvalid         <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
      if (int'(wr_word) == 0) divisor <= wdata[15:0];
      for (int i = 0; i < num_ch; i++) begin
        if (int'(wr_word) == i + 1) channel_config[i] <= wdata[3:0];
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Read data mux
  always_comb begin
    rd_value = '0;
    rd_error = 1'b0;
    case (int'(rd_word))
      0:           rd_value[15:0] = divisor;
      status_word: begin
        rd_value[3:0] = count;
        rd_value[8]   = overflow;
      end
      data_word:   if (count != 4'd0) rd_value = {1'b1, 19'b0, head};  // Empty reads 0
      default: begin
        rd_error = 1'b1;  // SLVERR unless a CHAN_CFG slot
        for (int i = 0; i < num_ch; i++) begin
          if (int'(rd_word) == i + 1) begin
            rd_value[3:0] = channel_config[i];
            rd_error      = 1'b0;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) rvalid <= 1'b0;
    else if (rd_fire) rvalid <= 1'b1;
    else if (rready) rvalid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata <= rd_value;
      rresp <= rd_error ? 2'b10 : 2'b00;
    end
  end

endmodule

//--- src/uart_rx_hub.sv
/* Four-channel UART receive hub top level
   Receivers share one tick, frames drain to a FIFO read over AXI4-Lite */
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module uart_rx_hub (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [`RX_NUM_CHANNELS-1:0]   rxd,      // One serial line per channel
  input  logic [`RX_AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [31:0]                   wdata,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`RX_AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready
);
  import uart_rx_pkg::*;

  logic                               sample_tick;
  logic [15:0]                        divisor;
  rx_config_t [`RX_NUM_CHANNELS-1:0]  channel_config;
  logic [`RX_NUM_CHANNELS-1:0]        frame_valid;
  logic [`RX_NUM_CHANNELS-1:0]        frame_ready;
  rx_frame_t [`RX_NUM_CHANNELS-1:0]   frames;
  logic                               pop;
  logic                               clear_overflow;
  rx_frame_t                          head;
  logic [3:0]                         count;
  logic                               overflow;

  baud_tick_gen u_tick (
    .clock       (clock),
    .reset       (reset),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  for (genvar i = 0; i < `RX_NUM_CHANNELS; i++) begin : g_channel
    uart_rx_channel u_rx (
      .clock          (clock),
      .reset          (reset),
      .sample_tick    (sample_tick),
      .channel_config (channel_config[i]),
      .channel_id     (chan_idx_t'(i)),  // Tagged into every frame
      .rxd            (rxd[i]),
      .frame_valid    (frame_valid[i]),
      .frame_ready    (frame_ready[i]),
      .frame          (frames[i])
    );
  end

  rx_frame_collector u_collector (
    .clock          (clock),
    .reset          (reset),
    .frame_valid    (frame_valid),
    .frames         (frames),
    .frame_ready    (frame_ready),
    .pop            (pop),
    .head           (head),
    .count          (count),
    .overflow       (overflow),
    .clear_overflow (clear_overflow)
  );

  axil_rx_regs u_regs (
    .clock          (clock),
    .reset          (reset),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .divisor        (divisor),
    .channel_config (channel_config),
    .pop            (pop),
    .clear_overflow (clear_overflow),
    .head           (head),
    .count          (count),
    .overflow       (overflow)
  );

endmodule

//--- verification/tb_clock_gen.sv
/* Testbench clock (4 ns period) and active-high reset held for 5 cycles */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;  // Released off the edge like every other input
  end

  always #2 clock = ~clock;  // 250 MHz

endmodule

//--- verification/uart_rx_hub_tb.sv
/* Testbench for the UART receive hub, drives serial frames and an AXI4-Lite host
   Checks every received frame, STATUS and error responses against the register map */
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module uart_rx_hub_tb;
  import uart_rx_pkg::*;

  typedef logic [`RX_AXI_ADDR_WIDTH-1:0] addr_t;

  localparam int divisor_value   = 3;
  localparam int bit_clocks      = 16 * divisor_value;  // 16 ticks per bit
  localparam int bit_ns          = bit_clocks * 4;
  localparam int total_frames    = 58;                  // Frames over all tests
  localparam int watchdog_ns     = total_frames * 12 * bit_ns + 100 * bit_ns;
  localparam int handshake_limit = 32;                  // Clocks to wait for ready or valid
  localparam int poll_limit      = bit_clocks;          // STATUS reads before giving up
  localparam addr_t reg_divisor  = addr_t'(8'h00);
  localparam addr_t reg_status   = addr_t'(8'h14);
  localparam addr_t reg_rx_data  = addr_t'(8'h18);
  localparam addr_t reg_unmapped = addr_t'(8'h1c);

  logic                        clock;
  logic                        reset;
  logic [`RX_NUM_CHANNELS-1:0] rxd;
  addr_t                       awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [31:0]                 wdata;
  logic                        wvalid;
  logic                        wready;
  logic [1:0]                  bresp;
  logic                        bvalid;
  logic                        bready;
  addr_t                       araddr;
  logic                        arvalid;
  logic                        arready;
  logic [31:0]                 rdata;
  logic [1:0]                  rresp;
  logic                        rvalid;
  logic                        rready;
  logic [31:0]                 rand_state;

  tb_clock_gen u_clock (.clock(clock), .reset(reset));

  uart_rx_hub DUT (.*);

  // Numerical Recipes LCG constants
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // RX_DATA word for a frame that is present
  function automatic logic [31:0] frame_word(input int chan, input logic perr,
                                             input logic ferr, input logic [7:0] data);
    rx_frame_t f;
    f.channel      = chan_idx_t'(chan);
    f.parity_error = perr;
    f.frame_error  = ferr;
    f.data         = data;
    return {1'b1, 19'b0, f};
  endfunction

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  task automatic axi_write(input addr_t addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge clock);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge clock);  // Ready is settled mid-cycle
    while (!(awready && wready)) begin
      waited++;
      if (waited > handshake_limit) report_failure("AW/W handshake never completed");
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clock);
    while (!bvalid) begin
      waited++;
      if (waited > handshake_limit) report_failure("Write response never arrived");
      @(negedge clock);
    end
    check_value("write bresp", 32'd0, 32'(bresp));  // Every write answers OKAY
    @(posedge clock);
    #1 bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    waited = 0;
    @(posedge clock);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clock);
    while (!arready) begin
      waited++;
      if (waited > handshake_limit) report_failure("AR handshake never completed");
      @(negedge clock);
    end
    @(posedge clock);
    #1 arvalid = 1'b0;
    @(negedge clock);
    while (!rvalid) begin
      waited++;
      if (waited > handshake_limit) report_failure("Read data never arrived");
      @(negedge clock);
    end
    data = rdata;
    resp = rresp;
    @(posedge clock);
    #1 rready = 1'b0;
  endtask

  task automatic write_config(input int chan, input rx_config_t cfg);
    axi_write(addr_t'(4 + 4 * chan), {28'b0, cfg});  // CHAN_CFG at 0x04 + 4*n
  endtask

  // Polls STATUS until the masked bits match; each read clears overflow
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                             output logic [31:0] word);
    int         polls;
    logic [1:0] resp;
    polls = 0;
    axi_read(reg_status, word, resp);
    while ((word & mask) != value) begin
      polls++;
      if (polls > poll_limit) report_failure("STATUS never reached the expected value");
      axi_read(reg_status, word, resp);
    end
  endtask

  task automatic hold_line(input int chan, input logic value, input int clocks);
    rxd[chan] = value;
    repeat (clocks) @(posedge clock);
    #1;
  endtask

  // One character, or only a short low pulse when glitch is set
  task automatic send_frame(input int chan, input logic [7:0] data, input rx_config_t cfg,
                            input bit bad_parity, input bit bad_stop, input bit glitch);
    logic parity_bit;
    @(posedge clock);
    #1;
    if (glitch) begin
      hold_line(chan, 1'b0, bit_clocks / 4);  // Gone well before samples 7 to 9
      hold_line(chan, 1'b1, 2 * bit_clocks);
    end else begin
      parity_bit = cfg.parity_mode[0] ? ~^data : ^data;  // Odd or even
      hold_line(chan, 1'b0, bit_clocks);
      for (int i = 0; i < 8; i++) hold_line(chan, data[i], bit_clocks);
      if (cfg.parity_mode[1]) hold_line(chan, parity_bit ^ bad_parity, bit_clocks);
      hold_line(chan, !(bad_stop && !cfg.two_stop), bit_clocks);
      if (cfg.two_stop) hold_line(chan, !bad_stop, bit_clocks);
      hold_line(chan, 1'b1, bit_clocks);  // Idle gap
    end
  endtask

  // Sends one frame and expects exactly it back from RX_DATA
  task automatic receive_and_check(input string test_name, input int chan,
                                   input logic [7:0] data, input rx_config_t cfg,
                                   input bit bad_parity, input bit bad_stop);
    logic [31:0] word;
    logic [1:0]  resp;
    send_frame(chan, data, cfg, bad_parity, bad_stop, 1'b0);
    wait_status(32'h0000_000f, 32'd1, word);
    axi_read(reg_rx_data, word, resp);
    check_value(test_name, frame_word(chan, bad_parity && cfg.parity_mode[1], bad_stop, data),
                word);
  endtask

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rx_config_t  cfg;
    logic [31:0] word;
    logic [1:0]  resp;
    logic [7:0]  sent [9];
    rxd        = '1;  // Lines idle high
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    rand_state = 32'h3535_dc47;
    @(negedge reset);

    // Divisor readback, then random bytes on each channel in turn
    axi_write(reg_divisor, 32'(divisor_value));
    axi_read(reg_divisor, word, resp);
    check_value("divisor readback", 32'(divisor_value), word);
    cfg = '{enable: 1'b1, parity_mode: 2'd0, two_stop: 1'b0};
    for (int ch = 0; ch < `RX_NUM_CHANNELS; ch++) write_config(ch, cfg);
    for (int ch = 0; ch < `RX_NUM_CHANNELS; ch++) begin
      for (int n = 0; n < 10; n++) begin
        rand_state = next_random(rand_state);
        receive_and_check("random bytes", ch, rand_state[31:24], cfg, 1'b0, 1'b0);
      end
    end

    // Even then odd parity, good and inverted parity bit
    cfg = '{enable: 1'b1, parity_mode: 2'd2, two_stop: 1'b0};
    write_config(1, cfg);
    receive_and_check("even parity good", 1, 8'hb5, cfg, 1'b0, 1'b0);
    receive_and_check("even parity bad", 1, 8'h3c, cfg, 1'b1, 1'b0);
    cfg.parity_mode = 2'd3;
    write_config(1, cfg);
    receive_and_check("odd parity good", 1, 8'h07, cfg, 1'b0, 1'b0);
    receive_and_check("odd parity bad", 1, 8'he1, cfg, 1'b1, 1'b0);

    // Stop bit checks with one and two stop bits
    cfg = '{enable: 1'b1, parity_mode: 2'd0, two_stop: 1'b0};
    write_config(2, cfg);
    receive_and_check("stop bit low", 2, 8'h5a, cfg, 1'b0, 1'b1);
    cfg.two_stop = 1'b1;
    write_config(2, cfg);
    receive_and_check("two stop good", 2, 8'ha5, cfg, 1'b0, 1'b0);
    receive_and_check("second stop low", 2, 8'h81, cfg, 1'b0, 1'b1);

    // Disabled channel and a short glitch both stay silent
    write_config(2, '0);
    send_frame(2, 8'h66, cfg, 1'b0, 1'b0, 1'b0);
    axi_read(reg_status, word, resp);
    check_value("disabled channel status", 32'd0, word);
    send_frame(3, 8'h00, cfg, 1'b0, 1'b0, 1'b1);
    axi_read(reg_status, word, resp);
    check_value("glitch status", 32'd0, word);
    axi_read(reg_rx_data, word, resp);
    check_value("empty rx_data", 32'd0, word);

    // Nine frames unread, the ninth overflows the 8-deep FIFO
    cfg = '{enable: 1'b1, parity_mode: 2'd0, two_stop: 1'b0};
    for (int n = 0; n < 9; n++) begin
      rand_state = next_random(rand_state);
      sent[n]    = rand_state[31:24];
      send_frame(0, sent[n], cfg, 1'b0, 1'b0, 1'b0);
      if (n < `RX_FIFO_DEPTH) wait_status(32'h0000_000f, 32'(n + 1), word);
    end
    wait_status(32'h0000_0100, 32'h0000_0100, word);
    check_value("overflow status", 32'h0000_0108, word);
    axi_read(reg_status, word, resp);
    check_value("overflow cleared", 32'h0000_0008, word);
    for (int n = 0; n < `RX_FIFO_DEPTH; n++) begin
      axi_read(reg_rx_data, word, resp);
      check_value("fifo order", frame_word(0, 1'b0, 1'b0, sent[n]), word);
    end

    // Unmapped address
    axi_read(reg_unmapped, word, resp);
    check_value("unmapped rresp", 32'd2, 32'(resp));  // SLVERR
    check_value("unmapped rdata", 32'd0, word);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+src
src/uart_rx_pkg.sv
src/baud_tick_gen.sv
src/uart_rx_channel.sv
src/rx_frame_collector.sv
src/axil_rx_regs.sv
src/uart_rx_hub.sv
verification/tb_clock_gen.sv
verification/uart_rx_hub_tb.sv

//--- Makefile
# Verilator build and run of the UART receive hub testbench

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module uart_rx_hub_tb -o sim_uart_rx_hub

run: compile
	./obj_dir/sim_uart_rx_hub

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
